/* verilog.f */
design/dp_pkg.sv
design/mem_pkg.sv
design/rf_if.sv
design/reg_file.sv
design/exec_unit.sv
design/fetch_unit.sv
design/datapath.sv
verification/tb_datapath.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_datapath -f verilog.f \
  && ./obj_dir/Vtb_datapath > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

/* program.hex */
// one 16-bit instruction word per line, from address 00 upward
D101
D202
A0C1
6020
8045
B8A3
C21F
D30E
A5B4
6731
8C10
4E2A
7F05
1234
ABCD
F00F

/* verification/tb_datapath.sv */
`timescale 1ns/1ps

module tb_datapath import dp_pkg::*, mem_pkg::*; ();

  // cycles allowed for reset release
  localparam int reset_timeout = 20;
  // length of the random phase
  localparam int random_cycles = 2000;

  logic      clk;
  logic      rst_n;
  reg_idx_t  readnum;
  reg_idx_t  writenum;
  logic      write;
  logic      vsel;
  word_t     datapath_in;
  logic      loada;
  logic      loadb;
  logic      asel;
  logic      bsel;
  logic      loadc;
  logic      loads;
  shift_op_e shift;
  alu_op_e   alu_op;
  logic      loadpc;
  logic      loadir;
  logic      msel;
  logic      mwrite;
  word_t     datapath_out;
  logic      status;
  addr_t     pc;
  word_t     instr;

  // reference state mirroring every datapath register
  word_t rf_m [num_regs];
  word_t mem_m [mem_depth];
  word_t a_m;
  word_t b_m;
  word_t c_m;
  logic  s_m;
  addr_t pc_m;
  word_t instr_m;
  word_t mdata_m;

  // mismatch counts per kind of result
  int word_errors;
  int status_errors;
  int addr_errors;

  datapath uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .readnum      (readnum),
    .writenum     (writenum),
    .write        (write),
    .vsel         (vsel),
    .datapath_in  (datapath_in),
    .loada        (loada),
    .loadb        (loadb),
    .asel         (asel),
    .bsel         (bsel),
    .loadc        (loadc),
    .loads        (loads),
    .shift        (shift),
    .alu_op       (alu_op),
    .loadpc       (loadpc),
    .loadir       (loadir),
    .msel         (msel),
    .mwrite       (mwrite),
    .datapath_out (datapath_out),
    .status       (status),
    .pc           (pc),
    .instr        (instr)
  );

  // 40 ns clock
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // reset low for five cycles and released off the edge
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      word_errors++;
      $display("error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_status(string name, logic exp, logic act);
    if (act !== exp) begin
      status_errors++;
      $display("error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) begin
      addr_errors++;
      $display("error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // B path shifter by one position
  function automatic word_t apply_shift(word_t v, shift_op_e op);
    case (op)
      shift_left:        return v << 1;
      shift_right:       return v >> 1;
      shift_right_arith: return word_t'($signed(v) >>> 1);
      default:           return v;
    endcase
  endfunction

  // add and sub wrap at 16 bits
  function automatic word_t alu_result(word_t a, word_t b, alu_op_e op);
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      default: return ~b;
    endcase
  endfunction

  // low five bits as a signed value
  function automatic word_t sign_extend_imm(word_t ins);
    return word_t'($signed(ins[imm5_width-1:0]));
  endfunction

  // all controls inactive
  task automatic idle();
    readnum     = '0;
    writenum    = '0;
    write       = 1'b0;
    vsel        = 1'b0;
    datapath_in = '0;
    loada       = 1'b0;
    loadb       = 1'b0;
    asel        = 1'b0;
    bsel        = 1'b0;
    loadc       = 1'b0;
    loads       = 1'b0;
    shift       = shift_none;
    alu_op      = alu_add;
    loadpc      = 1'b0;
    loadir      = 1'b0;
    msel        = 1'b0;
    mwrite      = 1'b0;
  endtask

  // ram image with zeros past the end of the file
  task automatic load_image();
    for (int i = 0; i < mem_depth; i++) begin
      mem_m[i] = '0;
    end
    $readmemh(mem_init_file, mem_m);
  endtask

  task automatic reset_model();
    for (int i = 0; i < num_regs; i++) begin
      rf_m[i] = '0;
    end
    a_m     = '0;
    b_m     = '0;
    c_m     = '0;
    s_m     = 1'b0;
    pc_m    = '0;
    instr_m = '0;
    // the ram kept reading address 0 during reset
    mdata_m = mem_m[0];
  endtask

  // one rising edge with every update taken from the old state
  task automatic update_model();
    word_t rd;
    word_t res;
    word_t old_mdata;
    addr_t addr;
    rd = rf_m[readnum];
    res = alu_result(asel ? word_t'(0) : a_m,
                     bsel ? sign_extend_imm(instr_m) : apply_shift(b_m, shift), alu_op);
    addr = msel ? c_m[$bits(addr_t)-1:0] : pc_m;
    // registered read returns the old word on a store
    old_mdata = mdata_m;
    mdata_m = mem_m[addr];
    if (mwrite) mem_m[addr] = b_m;
    if (write) rf_m[writenum] = vsel ? datapath_in : c_m;
    if (loadc) c_m = res;
    if (loads) s_m = (res == '0);
    if (loada) a_m = rd;
    if (loadb) b_m = rd;
    if (loadpc) pc_m = pc_m + addr_t'(1);
    if (loadir) instr_m = old_mdata;
  endtask

  task automatic compare_outputs();
    check_word("datapath_out", c_m, datapath_out);
    check_status("status", s_m, status);
    check_addr("pc", pc_m, pc);
    check_word("instr", instr_m, instr);
  endtask

  // model step at the edge and compare at +2 where the next drive starts
  task automatic tick();
    @(posedge clk);
    update_model();
    #2;
    compare_outputs();
  endtask

  task automatic wait_reset(output bit released);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < reset_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    released = (rst_n === 1'b1);
  endtask

  // write each register and pass it through A into C
  // instr is still zero here so sximm5 adds nothing
  task automatic run_writeback();
    word_t v;
    v = '0;
    for (int r = 0; r < num_regs; r++) begin
      v = word_t'($urandom);
      // external value into register r
      idle();
      write = 1'b1;
      writenum = reg_idx_t'(r);
      vsel = 1'b1;
      datapath_in = v;
      tick();
      // register r into A
      idle();
      readnum = reg_idx_t'(r);
      loada = 1'b1;
      tick();
      // A plus the zero immediate
      idle();
      bsel = 1'b1;
      loadc = 1'b1;
      loads = 1'b1;
      tick();
      check_word("datapath_out", v, datapath_out);
      check_status("status", v == '0, status);
    end
    // with vsel low C goes back into register 0
    idle();
    write = 1'b1;
    tick();
    idle();
    loada = 1'b1;
    tick();
    idle();
    bsel = 1'b1;
    loadc = 1'b1;
    tick();
    check_word("datapath_out", v, datapath_out);
  endtask

  // address in one cycle and loadir in the next
  // image words arrive in order
  task automatic run_fetch();
    for (int i = 0; i < 16; i++) begin
      idle();
      tick();
      idle();
      loadir = 1'b1;
      loadpc = 1'b1;
      tick();
      check_word("instr", mem_m[i], instr);
      check_addr("pc", addr_t'(i + 1), pc);
    end
    for (int i = 16; i < mem_depth - 1; i++) begin
      idle();
      loadpc = 1'b1;
      tick();
    end
    check_addr("pc", addr_t'(mem_depth - 1), pc);
    idle();
    loadpc = 1'b1;
    tick();
    check_addr("pc", '0, pc);
  endtask

  // store B at C's low byte and fetch it back through msel
  task automatic run_store();
    word_t sa;
    word_t sd;
    sa = word_t'($urandom) & 16'h00ff;
    sd = word_t'($urandom);
    idle();
    write = 1'b1;
    writenum = 3'd1;
    vsel = 1'b1;
    datapath_in = sa;
    tick();
    idle();
    write = 1'b1;
    writenum = 3'd2;
    vsel = 1'b1;
    datapath_in = sd;
    readnum = 3'd1;
    loadb = 1'b1;
    tick();
    // C takes 0 + B while B picks up the store data
    idle();
    asel = 1'b1;
    loadc = 1'b1;
    readnum = 3'd2;
    loadb = 1'b1;
    tick();
    check_word("datapath_out", sa, datapath_out);
    idle();
    msel = 1'b1;
    mwrite = 1'b1;
    tick();
    idle();
    msel = 1'b1;
    tick();
    idle();
    loadir = 1'b1;
    tick();
    check_word("instr", sd, instr);
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] d;
    r = $urandom;
    d = $urandom;
    readnum  = r[2:0];
    writenum = r[5:3];
    write    = r[6];
    vsel     = r[7];
    loada    = r[8];
    loadb    = r[9];
    asel     = r[10];
    bsel     = r[11];
    loadc    = r[12];
    loads    = r[13];
    shift    = shift_op_e'(r[15:14]);
    alu_op   = alu_op_e'(r[17:16]);
    loadpc   = r[18];
    loadir   = r[19];
    msel     = r[20];
    // stores are rarer so fetched words stay varied
    mwrite   = (r[23:21] == 3'd0);
    // zero now and then so the flag sets
    datapath_in = (d[18:16] == 3'd0) ? word_t'(0) : d[15:0];
  endtask

  initial begin
    bit released;
    void'($urandom(32'h6981d4f6));
    word_errors = 0;
    status_errors = 0;
    addr_errors = 0;
    idle();
    load_image();
    wait_reset(released);
    if (!released) begin
      $display("reset was not released within %0d cycles", reset_timeout);
      $display("Verification failed");
      $finish;
    end else begin
      #1;
      reset_model();
      // everything visible is cleared by reset
      check_word("datapath_out", '0, datapath_out);
      check_status("status", 1'b0, status);
      check_addr("pc", '0, pc);
      check_word("instr", '0, instr);
      run_writeback();
      run_fetch();
      run_store();
      for (int n = 0; n < random_cycles; n++) begin
        drive_random();
        tick();
      end
      idle();
      $display("errors: word %0d, status %0d, addr %0d",
               word_errors, status_errors, addr_errors);
      if (word_errors + status_errors + addr_errors == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath import dp_pkg::*, mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // register file control and write-back
  input  reg_idx_t  readnum,
  input  reg_idx_t  writenum,
  input  logic      write,
  input  logic      vsel,
  input  word_t     datapath_in,

  // operand and result loads
  input  logic      loada,
  input  logic      loadb,
  input  logic      asel,
  input  logic      bsel,
  input  logic      loadc,
  input  logic      loads,
  input  shift_op_e shift,
  input  alu_op_e   alu_op,

  // pc and memory control
  input  logic      loadpc,
  input  logic      loadir,
  input  logic      msel,
  input  logic      mwrite,

  // controller view
  output word_t     datapath_out,
  output logic      status,
  output addr_t     pc,
  output word_t     instr
);

  // execute to fetch link
  word_t c_value;
  word_t b_value;

  // register file connection
  rf_if rf ();

  // indices and strobe come straight from the controller ports
  assign rf.readnum  = readnum;
  assign rf.writenum = writenum;
  assign rf.write    = write;

  reg_file u_reg_file (
    .clk   (clk),
    .rst_n (rst_n),
    .rf    (rf.file)
  );

  exec_unit u_exec_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .rf          (rf.user),
    .datapath_in (datapath_in),
    .vsel        (vsel),
    .loada       (loada),
    .loadb       (loadb),
    .loadc       (loadc),
    .loads       (loads),
    .asel        (asel),
    .bsel        (bsel),
    .shift       (shift),
    .alu_op      (alu_op),
    .instr       (instr),
    .c_value     (c_value),
    .b_value     (b_value),
    .status      (status)
  );

  fetch_unit u_fetch_unit (
    .clk     (clk),
    .rst_n   (rst_n),
    .loadpc  (loadpc),
    .loadir  (loadir),
    .msel    (msel),
    .mwrite  (mwrite),
    .c_value (c_value),
    .b_value (b_value),
    .pc      (pc),
    .instr   (instr)
  );

  // C is the datapath result
  assign datapath_out = c_value;

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import dp_pkg::*, mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  loadpc,
  input  logic  loadir,
  input  logic  msel,
  input  logic  mwrite,
  input  word_t c_value,
  input  word_t b_value,
  output addr_t pc,
  output word_t instr
);

  // shared read/write address
  addr_t addr;

  // ram array and its registered read data
  word_t mem [mem_depth];
  word_t mdata;

  // program counter
  // steps by one, wraps at the top of memory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (loadpc) begin
      pc <= pc + addr_t'(1);
    end
  end

  // address select
  // msel high uses the low byte of C for loads and stores
  assign addr = msel ? c_value[$bits(addr_t)-1:0] : pc;

  // words past the end of the image read as zero
  initial begin
    for (int i = 0; i < mem_depth; i++) begin
      mem[i] = '0;
    end
    $readmemh(mem_init_file, mem);
  end

  // single port ram
  // read is registered, a write cycle returns the old word
  always @(posedge clk) begin
    if (mwrite) begin
      mem[addr] <= b_value;
    end
    mdata <= mem[addr];
  end

  // instruction register
  // loadir one cycle after the address was presented
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr <= '0;
    end else if (loadir) begin
      instr <= mdata;
    end
  end

  // a store to an unknown address has no defined target
  a_store_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    mwrite |-> !$isunknown(addr)
  ) else $error("fetch_unit store with unknown address");

endmodule

/* design/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import dp_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  rf_if.user        rf,
  input  word_t     datapath_in,
  input  logic      vsel,
  input  logic      loada,
  input  logic      loadb,
  input  logic      loadc,
  input  logic      loads,
  input  logic      asel,
  input  logic      bsel,
  input  shift_op_e shift,
  input  alu_op_e   alu_op,
  input  word_t     instr,
  output word_t     c_value,
  output word_t     b_value,
  output logic      status
);

  // operand and result registers
  word_t a_q;
  word_t b_q;
  word_t c_q;

  // combinational path from registers to the alu output
  word_t shift_out;
  word_t sximm5;
  word_t ain;
  word_t bin;
  word_t alu_out;
  logic  zero;

  // write-back select
  // vsel high takes the external input, low takes C
  assign rf.write_data = vsel ? datapath_in : c_q;

  // A and B both capture the register file read port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      if (loada) a_q <= rf.read_data;
      if (loadb) b_q <= rf.read_data;
    end
  end

  // shifter on B, one bit per operation
  always_comb begin
    case (shift)
      shift_none:        shift_out = b_q;
      shift_left:        shift_out = {b_q[$bits(word_t)-2:0], 1'b0};
      shift_right:       shift_out = {1'b0, b_q[$bits(word_t)-1:1]};
      shift_right_arith: shift_out = {b_q[$bits(word_t)-1], b_q[$bits(word_t)-1:1]};
      default:           shift_out = b_q;
    endcase
  end

  // immediate from the low instruction bits, sign extended
  assign sximm5 = {{($bits(word_t) - imm5_width){instr[imm5_width-1]}},
                   instr[imm5_width-1:0]};

  // operand selects
  // asel forces a to zero, so a plain add passes B through
  assign ain = asel ? '0 : a_q;
  assign bin = bsel ? sximm5 : shift_out;

  // alu, add and sub wrap at the word width
  always_comb begin
    case (alu_op)
      alu_add:   alu_out = ain + bin;
      alu_sub:   alu_out = ain - bin;
      alu_and:   alu_out = ain & bin;
      alu_not_b: alu_out = ~bin;
      default:   alu_out = '0;
    endcase
  end

  // zero flag
  assign zero = (alu_out == '0);

  // result and status registers
  // status holds its value while loads is low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      c_q    <= '0;
      status <= 1'b0;
    end else begin
      if (loadc) c_q <= alu_out;
      if (loads) status <= zero;
    end
  end

  // C feeds the data address, B is store data
  assign c_value = c_q;
  assign b_value = b_q;

  // controls that shape a captured result must be driven
  a_shift_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    (loadc || loads) |-> !$isunknown(shift)
  ) else $error("exec_unit result load with unknown shift");

  a_alu_op_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    (loadc || loads) |-> !$isunknown(alu_op)
  ) else $error("exec_unit result load with unknown alu_op");

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file import dp_pkg::*; (
  input logic clk,
  input logic rst_n,
  rf_if.file  rf
);

  // register storage, one word per index
  word_t regs [num_regs];

  // one register per index, each with its own write decode
  for (genvar i = 0; i < num_regs; i++) begin : g_reg
    logic we;

    // this register is the write target
    assign we = rf.write && (rf.writenum == reg_idx_t'(i));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        regs[i] <= '0;
      end else if (we) begin
        regs[i] <= rf.write_data;
      end
    end
  end

  // read port, combinational on readnum
  // a write at this edge shows up on read_data the cycle after
  assign rf.read_data = regs[rf.readnum];

  // a write to an unknown index would corrupt an arbitrary register
  a_writenum_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    rf.write |-> !$isunknown(rf.writenum)
  ) else $error("reg_file write with unknown writenum");

endmodule

/* design/rf_if.sv */
`timescale 1ns/1ps

// register file port as seen by the execute unit
// one write port and one read port, all plain levels
interface rf_if import dp_pkg::*; ();

  // read index, read_data follows it in the same cycle
  reg_idx_t readnum;

  // write index and strobe, sampled at the rising clk
  reg_idx_t writenum;
  logic     write;

  // write-back value from the execute unit
  word_t    write_data;

  // selected register contents
  word_t    read_data;

  // register file side
  modport file (
    input  readnum,
    input  writenum,
    input  write,
    input  write_data,
    output read_data
  );

  // execute unit side
  // indices and strobe come from the controller, not from here
  modport user (
    output write_data,
    input  read_data
  );

endinterface

/* design/mem_pkg.sv */
package mem_pkg;

  // instruction and data memory, one word per address
  localparam int mem_depth = 256;

  // address width follows the depth
  // the pc and the data address share this type
  typedef logic [$clog2(mem_depth)-1:0] addr_t;

  // hex image loaded into the ram at start
  // also read by the testbench model
  localparam string mem_init_file = "program.hex";

endpackage

/* design/dp_pkg.sv */
package dp_pkg;

  // datapath word, shared by every block and the testbench
  typedef logic [15:0] word_t;

  // register file size and its index width
  localparam int num_regs = 8;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  // signed immediate taken from the low instruction bits
  localparam int imm5_width = 5;

  // shifter control on the B path
  // 01 fills with zero, 10 is logical, 11 copies the msb
  typedef enum logic [1:0] {
    shift_none        = 2'b00,
    shift_left        = 2'b01,
    shift_right       = 2'b10,
    shift_right_arith = 2'b11
  } shift_op_e;

  // alu function select
  // sub is a minus b, not_b ignores a
  typedef enum logic [1:0] {
    alu_add   = 2'b00,
    alu_sub   = 2'b01,
    alu_and   = 2'b10,
    alu_not_b = 2'b11
  } alu_op_e;

endpackage
